// File: build.f
source/rvExecPkg.sv
source/instrWriteSlave.sv
source/instrFifo.sv
source/controller.sv
source/alu.sv
source/execUnit.sv
source/execTop.sv
tb/tbExecTop.sv

// File: run.sh
#!/bin/bash
# Compile and run the execution subsystem testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tbExecTop -o simExecTop
./obj_dir/simExecTop | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run failed"
    exit 1
fi
echo "Run finished without failure"

// File: source/alu.sv
// Combinational RV32I integer ALU
`timescale 1ns/1ps

module alu
    import rvExecPkg::*;
(
    input  aluOp_t aluOp,
    input  word_t  opA,
    input  word_t  opB,
    output word_t  result
);

    logic [4:0] shamt;

    assign shamt = opB[4:0];    // RV32I shifts use five bits only

    always_comb begin
        case (aluOp)
            ALU_ADD:   result = opA + opB;
            ALU_SUB:   result = opA - opB;
            ALU_SLT:   result = {31'b0, $signed(opA) < $signed(opB)};
            ALU_SLTU:  result = {31'b0, opA < opB};
            ALU_XOR:   result = opA ^ opB;
            ALU_SLL:   result = opA << shamt;
            ALU_SRL:   result = opA >> shamt;
            ALU_SRA:   result = word_t'($signed(opA) >>> shamt);
            ALU_OR:    result = opA | opB;
            ALU_AND:   result = opA & opB;
            ALU_PASSB: result = opB;
            default:   result = '0;
        endcase
    end

endmodule

// File: source/controller.sv
// RV32I decoder for the ALU, immediate and auipc instruction groups
`timescale 1ns/1ps

module controller
    import rvExecPkg::*;
(
    input  opcode_t    opcode,
    input  funct3_t    func3,
    input  funct7_t    func7,
    output aluOp_t     aluOp,
    output logic       aluSrcImm,
    output resultSel_t resultSel,
    output logic       regWrite
);

    // Shared func3 table of the register and immediate forms
    function automatic aluOp_t decodeArith(funct3_t f3, logic subSel, logic sraSel);
        case (f3)
            3'b000:  return subSel ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sraSel ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        resultSel = RES_ALU;
        regWrite  = 1'b0;   // Loads, stores, branches and jumps fall through here

        case (opcode)
            OP_REG: begin
                aluOp    = decodeArith(func3, func7[5], func7[5]);
                regWrite = 1'b1;
            end
            OP_IMM: begin
                // No subi, func7 only picks srai over srli
                aluOp     = decodeArith(func3, 1'b0, func7[5]);
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            OP_LUI: begin
                aluOp     = ALU_PASSB;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            OP_AUIPC: begin
                resultSel = RES_PC_IMM;     // pc + upper immediate
                regWrite  = 1'b1;
            end
            default: begin
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

// File: source/execTop.sv
// Execution subsystem top joining the AXI write slave, instruction FIFO and execution unit
`timescale 1ns/1ps

module execTop
    import rvExecPkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rstN,
    // AXI4-Lite write channels
    input  logic       awvalid,
    output logic       awready,
    input  word_t      awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  word_t      wdata,
    input  logic [3:0] wstrb,
    output logic       bvalid,
    input  logic       bready,
    output axiResp_t   bresp,
    // Writeback port
    output logic       wbValid,
    input  logic       wbReady,
    output regIdx_t    wbRd,
    output word_t      wbData
);

    logic  push;
    word_t pushData;
    logic  full;
    logic  pop;
    word_t popData;
    logic  empty;

    instrWriteSlave i_instrWriteSlave (
        .clk      (clk),
        .rstN     (rstN),
        .awvalid  (awvalid),
        .awaddr   (awaddr),
        .awready  (awready),
        .wvalid   (wvalid),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .push     (push),
        .pushData (pushData),
        .full     (full)
    );

    instrFifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_instrFifo (
        .clk      (clk),
        .rstN     (rstN),
        .push     (push),
        .pushData (pushData),
        .full     (full),
        .pop      (pop),
        .popData  (popData),
        .empty    (empty)
    );

    execUnit i_execUnit (
        .clk     (clk),
        .rstN    (rstN),
        .empty   (empty),
        .pop     (pop),
        .popData (popData),
        .wbValid (wbValid),
        .wbReady (wbReady),
        .wbRd    (wbRd),
        .wbData  (wbData)
    );

endmodule

// File: source/execUnit.sv
// Execution unit that pops, decodes and executes instructions and reports writebacks
`timescale 1ns/1ps

module execUnit
    import rvExecPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    // Instruction FIFO
    input  logic    empty,
    output logic    pop,
    input  word_t   popData,
    // Writeback port
    output logic    wbValid,
    input  logic    wbReady,
    output regIdx_t wbRd,
    output word_t   wbData
);

    word_t      regFile [32];
    word_t      pc;
    opcode_t    opcode;
    funct3_t    func3;
    funct7_t    func7;
    regIdx_t    rd;
    regIdx_t    rs1;
    regIdx_t    rs2;
    word_t      immI;
    word_t      immU;
    word_t      opB;
    word_t      aluResult;
    word_t      result;
    aluOp_t     aluOp;
    logic       aluSrcImm;
    resultSel_t resultSel;
    logic       regWrite;

    // Instruction fields
    assign opcode = popData[6:0];
    assign rd     = popData[11:7];
    assign func3  = popData[14:12];
    assign rs1    = popData[19:15];
    assign rs2    = popData[24:20];
    assign func7  = popData[31:25];

    assign immI = {{20{popData[31]}}, popData[31:20]};
    assign immU = {popData[31:12], 12'b0};

    controller i_controller (
        .opcode    (opcode),
        .func3     (func3),
        .func7     (func7),
        .aluOp     (aluOp),
        .aluSrcImm (aluSrcImm),
        .resultSel (resultSel),
        .regWrite  (regWrite)
    );

    // lui is the only immediate user that takes the U form through the ALU
    assign opB = !aluSrcImm ? regFile[rs2] : (opcode == OP_LUI) ? immU : immI;

    alu i_alu (
        .aluOp  (aluOp),
        .opA    (regFile[rs1]),
        .opB    (opB),
        .result (aluResult)
    );

    assign result = (resultSel == RES_PC_IMM) ? pc + immU : aluResult;
    assign pop    = !empty && !wbValid;   // One instruction in flight at most

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
            pc      <= '0;
            wbValid <= 1'b0;
        end else begin
            if (pop) begin
                pc      <= pc + 32'd4;
                wbValid <= regWrite;
                if (regWrite && rd != '0) begin
                    regFile[rd] <= result;  // x0 stays zero
                end
            end else if (wbReady) begin
                wbValid <= 1'b0;
            end
        end
    end

    // Payload held until the host takes it
    always_ff @(posedge clk) begin
        if (pop && regWrite) begin
            wbRd   <= rd;
            wbData <= result;
        end
    end

    wbHold: assert property (@(posedge clk) disable iff (!rstN)
        wbValid && !wbReady |=> wbValid && $stable(wbRd) && $stable(wbData))
        else $error("Writeback changed before it was accepted");

endmodule

// File: source/instrFifo.sv
// Synchronous circular FIFO holding instruction words between slave and execution unit
`timescale 1ns/1ps

module instrFifo
    import rvExecPkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  push,
    input  word_t pushData,
    output logic  full,
    input  logic  pop,
    output word_t popData,
    output logic  empty
);

    localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CntW = $clog2(DEPTH + 1);

    word_t           mem [DEPTH];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doPush;
    logic            doPop;

    assign full    = (count == CntW'(DEPTH));
    assign empty   = (count == '0);
    assign doPush  = push && !full;
    assign doPop   = pop && !empty;
    assign popData = mem[rdPtr];    // Head entry, valid when not empty

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            count <= count + CntW'(doPush) - CntW'(doPop);
        end
    end

    // A push into a full buffer would be dropped
    pushNotFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
        else $error("Instruction push while FIFO is full");

    popNotEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
        else $error("Instruction pop from an empty FIFO");

endmodule

// File: source/instrWriteSlave.sv
// AXI4-Lite write slave that pushes instruction words into the instruction FIFO
`timescale 1ns/1ps

module instrWriteSlave
    import rvExecPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    // Write address channel
    input  logic     awvalid,
    input  word_t    awaddr,
    output logic     awready,
    // Write data channel
    input  logic     wvalid,
    input  word_t    wdata,
    input  logic [3:0] wstrb,
    output logic     wready,
    // Write response channel
    output logic     bvalid,
    input  logic     bready,
    output axiResp_t bresp,
    // FIFO side
    output logic     push,
    output word_t    pushData,
    input  logic     full
);

    typedef enum logic {
        slvIdle,
        slvResp
    } slvState_t;

    slvState_t state;
    logic      addrOk;
    logic      strbOk;
    logic      accept;

    assign addrOk = (awaddr == INSTR_ADDR);
    assign strbOk = &wstrb;     // Only full word writes are taken

    // Good address waits while full, bad address is answered at once
    assign accept = (state == slvIdle) && awvalid && wvalid && (!full || !addrOk);

    assign awready  = accept;
    assign wready   = accept;
    assign push     = accept && addrOk && strbOk;
    assign pushData = wdata;
    assign bvalid   = (state == slvResp);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= slvIdle;
            bresp <= RESP_OKAY;
        end else begin
            case (state)
                slvIdle: begin
                    if (accept) begin
                        state <= slvResp;
                        bresp <= (addrOk && strbOk) ? RESP_OKAY : RESP_SLVERR;
                    end
                end
                slvResp: begin
                    if (bready) begin
                        state <= slvIdle;   // Response taken
                    end
                end
                default: state <= slvIdle;
            endcase
        end
    end

endmodule

// File: source/rvExecPkg.sv
// RV32I execution subsystem shared types, ALU operations, opcodes and AXI codes
package rvExecPkg;

    typedef logic [31:0] word_t;    // Data, instruction or address word
    typedef logic [4:0]  regIdx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [1:0]  axiResp_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB   // Operand B straight through, lui
    } aluOp_t;

    typedef enum logic {
        RES_ALU,
        RES_PC_IMM  // auipc
    } resultSel_t;

    // Major opcodes that write a register
    localparam opcode_t OP_REG   = 7'b0110011;
    localparam opcode_t OP_IMM   = 7'b0010011;
    localparam opcode_t OP_LUI   = 7'b0110111;
    localparam opcode_t OP_AUIPC = 7'b0010111;

    localparam axiResp_t RESP_OKAY   = 2'b00;
    localparam axiResp_t RESP_SLVERR = 2'b10;

    localparam word_t INSTR_ADDR = 32'h0000_0000;   // Instruction push register

endpackage

// File: tb/tbExecTop.sv
// Directed testbench for the RV32I execution subsystem, checked against a reference model
`timescale 1ns/1ps

module tbExecTop;

    localparam int FIFO_DEPTH = 4;

    logic        clk;
    logic        rstN;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        wbValid;
    logic        wbReady;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    logic [31:0] refRegs [32];      // Model register file
    logic [31:0] refPc;
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    integer      seed;
    int          errors;
    int          issued;
    int          cycles;
    int          passCount;
    int          failCount;

    execTop #(.FIFO_DEPTH(FIFO_DEPTH)) i_execTop (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'h13};
    endfunction

    // RV32I rules for the instruction groups that write a register
    task automatic applyModel(input logic [31:0] ins);
        logic [6:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic        wr;
        opc = ins[6:0];
        a   = refRegs[ins[19:15]];
        b   = (opc == 7'h33) ? refRegs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        wr  = 1'b1;
        case (opc)
            7'h37: r = {ins[31:12], 12'b0};             // lui
            7'h17: r = refPc + {ins[31:12], 12'b0};     // auipc
            7'h33, 7'h13: begin
                case (ins[14:12])
                    3'd0:    r = (opc == 7'h33 && ins[30]) ? a - b : a + b;
                    3'd1:    r = a << b[4:0];
                    3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd3:    r = (a < b) ? 32'd1 : 32'd0;
                    3'd4:    r = a ^ b;
                    3'd5: begin
                        if (ins[30]) begin
                            r = $signed(a) >>> b[4:0];  // Sign bit fills
                        end else begin
                            r = a >> b[4:0];
                        end
                    end
                    3'd6:    r = a | b;
                    default: r = a & b;
                endcase
            end
            default: begin
                wr = 1'b0;  // Loads, stores, branches, jumps
                r  = 32'd0;
            end
        endcase
        if (wr) begin
            expRd.push_back(ins[11:7]);
            expData.push_back(r);
            if (ins[11:7] != 5'd0) begin
                refRegs[ins[11:7]] = r;
            end
        end
        refPc = refPc + 32'd4;
    endtask

    task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
        int waitCnt;
        waitCnt = 0;
        @(posedge clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        bready  <= 1'b1;
        issued++;
        @(negedge clk);
        while (!awready && waitCnt < 1000) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!awready) begin
            $display("ERROR: write to address %h was never accepted", addr);
            errors++;
        end else if (wready !== 1'b1) begin
            $display("MISMATCH at %0t: wready low while awready accepts the write", $time);
            errors++;
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid && waitCnt < 1000) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!bvalid) begin
            $display("ERROR: no write response arrived for address %h", addr);
            errors++;
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic sendInstr(input logic [31:0] ins);
        logic [1:0] resp;
        applyModel(ins);
        axiWrite(32'h0, ins, 4'hF, resp);
        if (resp !== 2'b00) begin
            $display("MISMATCH at %0t: bresp %b for %h, expected OKAY", $time, resp, ins);
            errors++;
        end
    endtask

    task automatic expectWb(input logic [4:0] rd, input logic [31:0] data);
        int waitCnt;
        waitCnt = 0;
        @(negedge clk);
        while (!wbValid && waitCnt < 1000) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!wbValid) begin
            $display("ERROR: expected writeback to x%0d never arrived", rd);
            errors++;
        end else if (wbRd !== rd || wbData !== data) begin
            $display("MISMATCH at %0t: writeback x%0d = %h, expected x%0d = %h",
                     $time, wbRd, wbData, rd, data);
            errors++;
        end
        @(posedge clk);
        wbReady <= 1'b1;
        @(posedge clk);
        wbReady <= 1'b0;
    endtask

    task automatic drainWb();
        while (expRd.size() > 0) begin
            expectWb(expRd.pop_front(), expData.pop_front());
        end
    endtask

    // lui plus addi, upper part rounded for the sign of the low twelve bits
    task automatic loadReg(input logic [4:0] rd, input logic [31:0] v);
        sendInstr({v[31:12] + 20'(v[11]), rd, 7'h37});
        sendInstr(iType(v[11:0], rd, 3'b000, rd));
        drainWb();
    endtask

    task automatic finishTest(input string name, input int errBefore);
        if (errors == errBefore) begin
            passCount++;
            $display("Test %s: ok", name);
        end else begin
            failCount++;
            $display("Test %s: %0d errors", name, errors - errBefore);
        end
    endtask

    task automatic aluRegOps();
        logic [3:0] ops [10];   // {func7 bit 5, func3}
        int         start;
        start = errors;
        ops   = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hD, 4'h6, 4'h7};
        loadReg(5'd1, $random(seed) | 32'h8000_0000);   // Negative operands
        loadReg(5'd2, $random(seed) | 32'h8000_0000);
        loadReg(5'd3, $random(seed) & 32'h7FFF_FFFF);
        for (int k = 0; k < 10; k++) begin
            sendInstr(rType({1'b0, ops[k][3], 5'b0}, 5'd2, 5'd1, ops[k][2:0], 5'(5 + k)));
            sendInstr(rType({1'b0, ops[k][3], 5'b0}, 5'd1, 5'd3, ops[k][2:0], 5'(15 + k)));
            drainWb();
        end
        finishTest("R-type", start);
    endtask

    task automatic aluImmOps();
        int start;
        start = errors;
        sendInstr(iType(12'hFFB, 5'd1, 3'b000, 5'd10));     // addi -5
        sendInstr(iType(12'hFFF, 5'd1, 3'b010, 5'd11));     // slti -1
        sendInstr(iType(12'hFFF, 5'd2, 3'b011, 5'd12));
        sendInstr(iType(12'hF00, 5'd3, 3'b100, 5'd13));
        drainWb();
        sendInstr(iType(12'h800, 5'd3, 3'b110, 5'd14));     // ori -2048
        sendInstr(iType(12'hFF0, 5'd2, 3'b111, 5'd15));
        sendInstr(iType(12'h007, 5'd1, 3'b001, 5'd16));     // slli 7
        sendInstr(iType(12'h009, 5'd2, 3'b101, 5'd17));     // srli 9
        drainWb();
        sendInstr(iType(12'h409, 5'd2, 3'b101, 5'd18));     // srai 9
        // Value shows on the port, x0 itself stays zero
        sendInstr(iType(12'h07B, 5'd1, 3'b000, 5'd0));
        sendInstr(rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd19));
        drainWb();
        finishTest("I-type", start);
    endtask

    task automatic upperImmOps();
        int start;
        start = errors;
        sendInstr({20'($random(seed)), 5'd20, 7'h37});
        sendInstr({20'($random(seed)), 5'd21, 7'h17});
        sendInstr({20'h0, 5'd22, 7'h17});
        drainWb();
        finishTest("lui/auipc", start);
    endtask

    task automatic rejectedWrites();
        logic [1:0] resp;
        int         start;
        start = errors;
        axiWrite(32'h4, iType(12'd77, 5'd0, 3'b000, 5'd23), 4'hF, resp);
        if (resp !== 2'b10) begin
            $display("MISMATCH at %0t: bresp %b for bad address, expected SLVERR", $time, resp);
            errors++;
        end
        axiWrite(32'h0, iType(12'd78, 5'd0, 3'b000, 5'd23), 4'h7, resp);
        if (resp !== 2'b10) begin
            $display("MISMATCH at %0t: bresp %b for partial strobe, expected SLVERR",
                     $time, resp);
            errors++;
        end
        sendInstr(iType(12'd55, 5'd0, 3'b000, 5'd23));
        sendInstr({20'h0, 5'd24, 7'h17});  // pc must not count the rejected words
        drainWb();
        finishTest("SLVERR", start);
    endtask

    task automatic watchStall();
        int held;
        held = 0;
        repeat (40) @(negedge clk);
        repeat (20) begin
            @(negedge clk);
            if (awvalid && !awready) begin
                held++;
            end
        end
        if (held != 20) begin
            $display("ERROR: slave kept accepting writes while the FIFO was full");
            errors++;
        end
    endtask

    task automatic backPressure();
        int start;
        start = errors;
        fork
            for (int k = 0; k < FIFO_DEPTH + 3; k++) begin
                sendInstr(iType(12'(3 * k + 1), 5'd3, 3'b000, 5'(25 + k)));
            end
            begin
                watchStall();
                drainWb();
            end
        join
        drainWb();
        finishTest("back-pressure", start);
    endtask

    task automatic nonWritingOps();
        int start;
        start = errors;
        sendInstr(32'h0020_A023);   // sw x2, 0(x1)
        sendInstr(32'h0020_8463);   // beq x1, x2, 8
        sendInstr(32'h0080_00EF);   // jal x1, 8
        sendInstr(32'h0000_A283);   // lw x5, 0(x1)
        sendInstr({20'h0, 5'd6, 7'h17});
        drainWb();
        finishTest("no-writeback", start);
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles <= issued * 50 + 2000) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles with %0d writes", cycles, issued);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed      = 78;
        errors    = 0;
        issued    = 0;
        passCount = 0;
        failCount = 0;
        refPc     = 32'd0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = 32'd0;
        end
        rstN    = 1'b0;
        awvalid = 1'b0;
        awaddr  = 32'd0;
        wvalid  = 1'b0;
        wdata   = 32'd0;
        wstrb   = 4'h0;
        bready  = 1'b0;
        wbReady = 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        aluRegOps();
        aluImmOps();
        upperImmOps();
        rejectedWrites();
        backPressure();
        nonWritingOps();
        $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (errors == 0 && failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
